// ==== Bender.yml ====
package:
  name: time_sync

sources:
  - design/tsync_pkg.sv
  - design/sample_ram.sv
  - design/metric_calc.sv
  - design/peak_search.sv
  - design/cp_remover.sv
  - design/time_sync.sv
  - target: test
    files:
      - tb/tb_time_sync.sv

// ==== design/cp_remover.sv ====
`timescale 1ns/10ps

module cp_remover
  import tsync_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      tx_done,
  input  logic      frame_found,
  input  buf_addr_t frame_idx,
  output buf_addr_t buf_addr,
  input  sample_t   buf_rdata,
  output logic      out_we,
  output out_addr_t out_addr,
  output sample_t   out_wdata,
  output logic      out_buff_full
);

  logic started;                          // copy launched for this burst
  logic copy_on;                          // reads still being issued
  logic [$clog2(FFT_LEN)-1:0]      pos_cnt;
  logic [$clog2(NUM_DATA_SYM)-1:0] sym_cnt;
  out_addr_t rd_idx;
  logic      last_rd;

  assign rd_idx  = {sym_cnt, pos_cnt};    // payload index s*FFT_LEN + j
  assign last_rd = copy_on && (sym_cnt == NUM_DATA_SYM - 1) && (pos_cnt == FFT_LEN - 1);

  // skip preamble and the prefix of every data symbol
  assign buf_addr = frame_idx + buf_addr_t'(PRE_LEN + CP_LEN)
                  + buf_addr_t'(sym_cnt * SYM_LEN) + buf_addr_t'(pos_cnt);

  assign out_wdata = buf_rdata;           // capture RAM output lines up with out_we

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      started       <= 1'b0;
      copy_on       <= 1'b0;
      pos_cnt       <= '0;
      sym_cnt       <= '0;
      out_we        <= 1'b0;
      out_addr      <= '0;
      out_buff_full <= 1'b0;
    end else if (tx_done) begin
      started       <= 1'b0;
      copy_on       <= 1'b0;
      pos_cnt       <= '0;
      sym_cnt       <= '0;
      out_we        <= 1'b0;
      out_addr      <= '0;
      out_buff_full <= 1'b0;
    end else begin
      if (frame_found && !started) begin
        started <= 1'b1;
        copy_on <= 1'b1;
      end else if (copy_on) begin
        if (last_rd) begin
          copy_on <= 1'b0;
          pos_cnt <= '0;
          sym_cnt <= '0;
        end else if (pos_cnt == FFT_LEN - 1) begin
          pos_cnt <= '0;
          sym_cnt <= sym_cnt + 1'b1;    // next symbol, prefix jumped
        end else begin
          pos_cnt <= pos_cnt + 1'b1;
        end
      end
      // write trails its read by one cycle
      out_we   <= copy_on;
      out_addr <= rd_idx;
      if (out_we && out_addr == OUT_DEPTH - 1) begin
        out_buff_full <= 1'b1;
      end
    end
  end

  no_write_when_full : assert property (@(posedge clk) disable iff (!rst_n)
    out_buff_full |-> !out_we)
    else $error("output buffer written after it was marked full");

endmodule

// ==== design/metric_calc.sv ====
`timescale 1ns/10ps

module metric_calc
  import tsync_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      tx_done,
  input  logic      sample_valid,
  input  sample_t   sample,
  output logic      metric_valid,
  output corr_t     corr,
  output energy_t   energy,
  output buf_addr_t cand_idx
);

  localparam int WIN_LEN = 2 * HALF_LEN;

  sample_t dly [WIN_LEN];       // dly[k] holds r[n-1-k]
  buf_addr_t pos_cnt;           // stream position n of the next sample

  // stage 1, new and retiring terms
  logic               v1;
  logic               prim1;
  buf_addr_t          idx1;
  logic signed [15:0] prod_new;  // r[n] * r[n-8]
  logic signed [15:0] prod_old;  // r[n-8] * r[n-16]
  logic        [15:0] sq_new;
  logic        [15:0] sq_old;

  // stage 2, running sums
  logic      v2;
  buf_addr_t idx2;
  corr_t     p_sum;
  energy_t   r_sum;

  ////////////////////////////////////////////////////////////////////////////
  // control path
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < WIN_LEN; k++) begin
        dly[k] <= '0;
      end
      pos_cnt      <= '0;
      v1           <= 1'b0;
      prim1        <= 1'b0;
      v2           <= 1'b0;
      metric_valid <= 1'b0;
      p_sum        <= '0;
      r_sum        <= '0;
    end else if (tx_done) begin
      for (int k = 0; k < WIN_LEN; k++) begin
        dly[k] <= '0;    // zero history keeps the first sums exact
      end
      pos_cnt      <= '0;
      v1           <= 1'b0;
      prim1        <= 1'b0;
      v2           <= 1'b0;
      metric_valid <= 1'b0;
      p_sum        <= '0;
      r_sum        <= '0;
    end else begin
      if (sample_valid) begin
        dly[0] <= sample;
        for (int k = 1; k < WIN_LEN; k++) begin
          dly[k] <= dly[k-1];
        end
        pos_cnt <= pos_cnt + 1'b1;
      end
      v1    <= sample_valid;
      prim1 <= pos_cnt >= WIN_LEN - 1;    // window complete with this sample
      if (v1) begin
        p_sum <= p_sum + prod_new - prod_old;
        r_sum <= r_sum + sq_new - sq_old;
      end
      v2           <= v1 && prim1;
      metric_valid <= v2;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // data path
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (sample_valid) begin
      prod_new <= sample * dly[HALF_LEN-1];
      prod_old <= dly[HALF_LEN-1] * dly[WIN_LEN-1];
      sq_new   <= sample * sample;
      sq_old   <= dly[HALF_LEN-1] * dly[HALF_LEN-1];
      idx1     <= pos_cnt - buf_addr_t'(WIN_LEN - 1);   // d = n - 15
    end
    idx2 <= idx1;
    // output alignment stage
    corr     <= p_sum;
    energy   <= r_sum;
    cand_idx <= idx2;
  end

endmodule

// ==== design/peak_search.sv ====
`timescale 1ns/10ps

module peak_search
  import tsync_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      tx_done,
  input  logic      metric_valid,
  input  corr_t     corr,
  input  energy_t   energy,
  input  buf_addr_t cand_idx,
  output logic      frame_found,
  output buf_addr_t frame_idx
);

  corr_t   best_p;
  energy_t best_r;
  logic    have_best;

  logic [39:0] p_sq_new, p_sq_best;
  logic [37:0] r_sq_new, r_sq_best;
  logic [77:0] lhs, rhs;
  logic        in_range;
  logic        take;

  // M(d) > M(b) without a divider
  assign p_sq_new  = corr * corr;
  assign p_sq_best = best_p * best_p;
  assign r_sq_new  = energy * energy;
  assign r_sq_best = best_r * best_r;
  assign lhs       = p_sq_new * r_sq_best;
  assign rhs       = p_sq_best * r_sq_new;

  assign in_range = metric_valid && !frame_found && (cand_idx < SEARCH_LEN);
  assign take     = in_range && (energy != '0) && (!have_best || lhs > rhs); // strict, ties stay

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      have_best   <= 1'b0;
      frame_idx   <= '0;
      frame_found <= 1'b0;
    end else if (tx_done) begin
      have_best   <= 1'b0;
      frame_idx   <= '0;
      frame_found <= 1'b0;
    end else begin
      if (take) begin
        have_best <= 1'b1;
        frame_idx <= cand_idx;
      end
      if (in_range && cand_idx == SEARCH_LEN - 1) begin
        frame_found <= 1'b1;    // held until tx_done
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      best_p <= corr;
      best_r <= energy;
    end
  end

  idx_in_search : assert property (@(posedge clk) disable iff (!rst_n)
    frame_found |-> frame_idx < SEARCH_LEN)
    else $error("frame_idx %0d outside search range", frame_idx);

endmodule

// ==== design/sample_ram.sv ====
`timescale 1ns/10ps

module sample_ram
  import tsync_pkg::*;
#(
  parameter int DEPTH = 16
) (
  input  logic                     clk,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] addr,
  input  sample_t                  wdata,
  output sample_t                  rdata
);

  sample_t mem [DEPTH];

  // registered read, a write shows the new word on the same edge
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
      rdata     <= wdata;
    end else begin
      rdata <= mem[addr];
    end
  end

  // read_ptr range errors from the top land here too
  addr_in_range : assert property (@(posedge clk)
    !$isunknown(addr) |-> addr < DEPTH)
    else $error("sample_ram address %0d beyond depth %0d", addr, DEPTH);

endmodule

// ==== design/time_sync.sv ====
`timescale 1ns/10ps

module time_sync
  import tsync_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      tx_done,
  input  logic      wren,
  input  sample_t   din,
  input  out_addr_t read_ptr,
  output sample_t   dout,
  output logic      out_buff_full,
  output buf_addr_t frame_idx
);

  logic      accept;
  logic      in_buff_full;
  buf_addr_t cap_cnt;
  buf_addr_t cap_addr;
  sample_t   cap_rdata;

  logic      metric_valid;
  corr_t     corr;
  energy_t   energy;
  buf_addr_t cand_idx;
  logic      frame_found;
  logic      copy_go;      // search done and window captured

  buf_addr_t cp_buf_addr;
  logic      out_we;
  out_addr_t cp_out_addr;
  sample_t   out_wdata;
  out_addr_t out_addr;
  sample_t   out_rdata;

  logic      rd_live;      // out_ram output is a readback word
  sample_t   dout_hold;

  ////////////////////////////////////////////////////////////////////////////
  // capture
  ////////////////////////////////////////////////////////////////////////////

  assign accept = wren && !in_buff_full;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cap_cnt      <= '0;
      in_buff_full <= 1'b0;
    end else if (tx_done) begin
      cap_cnt      <= '0;
      in_buff_full <= 1'b0;
    end else if (accept) begin
      cap_cnt <= cap_cnt + 1'b1;
      if (cap_cnt == BUF_DEPTH - 1) begin
        in_buff_full <= 1'b1;
      end
    end
  end

  // cp_remover owns the port once capture is over
  assign cap_addr = in_buff_full ? cp_buf_addr : cap_cnt;
  assign out_addr = out_buff_full ? read_ptr : cp_out_addr;

  // copy starts only once the whole window is in the capture memory
  assign copy_go = frame_found && in_buff_full;

  sample_ram #(.DEPTH(BUF_DEPTH)) cap_ram (
    .clk   (clk),
    .we    (accept),
    .addr  (cap_addr),
    .wdata (din),
    .rdata (cap_rdata)
  );

  metric_calc u_metric (
    .clk          (clk),
    .rst_n        (rst_n),
    .tx_done      (tx_done),
    .sample_valid (accept),
    .sample       (din),
    .metric_valid (metric_valid),
    .corr         (corr),
    .energy       (energy),
    .cand_idx     (cand_idx)
  );

  peak_search u_peak (
    .clk          (clk),
    .rst_n        (rst_n),
    .tx_done      (tx_done),
    .metric_valid (metric_valid),
    .corr         (corr),
    .energy       (energy),
    .cand_idx     (cand_idx),
    .frame_found  (frame_found),
    .frame_idx    (frame_idx)
  );

  cp_remover u_cp (
    .clk           (clk),
    .rst_n         (rst_n),
    .tx_done       (tx_done),
    .frame_found   (copy_go),
    .frame_idx     (frame_idx),
    .buf_addr      (cp_buf_addr),
    .buf_rdata     (cap_rdata),
    .out_we        (out_we),
    .out_addr      (cp_out_addr),
    .out_wdata     (out_wdata),
    .out_buff_full (out_buff_full)
  );

  sample_ram #(.DEPTH(OUT_DEPTH)) out_ram (
    .clk   (clk),
    .we    (out_we),
    .addr  (out_addr),
    .wdata (out_wdata),
    .rdata (out_rdata)
  );

  ////////////////////////////////////////////////////////////////////////////
  // readback
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_live <= 1'b0;
    end else begin
      rd_live <= out_buff_full;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_live) begin
      dout_hold <= out_rdata;
    end
  end

  assign dout = rd_live ? out_rdata : dout_hold;   // last word held between bursts

endmodule

// ==== design/tsync_pkg.sv ====
package tsync_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // frame geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int FFT_LEN      = 16;                   // symbol body
  localparam int CP_LEN       = 4;                    // cyclic prefix
  localparam int HALF_LEN     = FFT_LEN / 2;          // correlation lag and window
  localparam int SYM_LEN      = CP_LEN + FFT_LEN;
  localparam int NUM_DATA_SYM = 3;
  localparam int PRE_LEN      = SYM_LEN;              // training symbol plus its prefix

  // capture window and derived sizes
  localparam int BUF_DEPTH    = 128;
  localparam int BURST_LEN    = PRE_LEN + NUM_DATA_SYM * SYM_LEN;
  localparam int SEARCH_LEN   = BUF_DEPTH - BURST_LEN;  // candidate start positions
  localparam int OUT_DEPTH    = NUM_DATA_SYM * FFT_LEN;

  ////////////////////////////////////////////////////////////////////////////
  // data types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic signed [7:0]  sample_t;
  typedef logic signed [19:0] corr_t;     // running P
  typedef logic        [18:0] energy_t;   // running R, never negative

  typedef logic [$clog2(BUF_DEPTH)-1:0] buf_addr_t;
  typedef logic [$clog2(OUT_DEPTH)-1:0] out_addr_t;

endpackage

// ==== tb/tb_time_sync.sv ====
`timescale 1ns/10ps

module tb_time_sync
  import tsync_pkg::*;
();

  localparam int BURSTS          = 2;
  localparam int BURST_WORDS     = BUF_DEPTH + 1 + OUT_DEPTH;  // samples, index, payload
  localparam int TRACE_WORDS     = BURSTS * BURST_WORDS;
  localparam int RESET_CYCLES    = 5;
  localparam int EXTRA_PULSES    = 6;
  localparam int WATCHDOG_CYCLES =
    4 * (BURSTS * (BUF_DEPTH + OUT_DEPTH + SEARCH_LEN) + RESET_CYCLES);
  localparam int SEED            = 58349;

  logic      clk;
  logic      rst_n;
  logic      tx_done;
  logic      wren;
  sample_t   din;
  out_addr_t read_ptr;
  sample_t   dout;
  logic      out_buff_full;
  buf_addr_t frame_idx;

  logic [7:0]  trace_mem [TRACE_WORDS];

  time_sync dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .tx_done       (tx_done),
    .wren          (wren),
    .din           (din),
    .read_ptr      (read_ptr),
    .dout          (dout),
    .out_buff_full (out_buff_full),
    .frame_idx     (frame_idx)
  );

  always #5 clk = ~clk;    // 10 ns period

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_idx(input string name, input buf_addr_t got, input buf_addr_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_sample(input string name, input sample_t got, input sample_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  // trace layout per burst: samples, then frame index, then payload
  function automatic sample_t trace_sample(input int burst, input int i);
    return sample_t'(trace_mem[burst * BURST_WORDS + i]);
  endfunction

  function automatic buf_addr_t exp_frame_idx(input int burst);
    return buf_addr_t'(trace_mem[burst * BURST_WORDS + BUF_DEPTH]);
  endfunction

  function automatic sample_t exp_payload(input int burst, input int j);
    return sample_t'(trace_mem[burst * BURST_WORDS + BUF_DEPTH + 1 + j]);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  // inputs change 1 ns after the rising edge
  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic feed_burst(input int burst);
    int gap;
    for (int i = 0; i < BUF_DEPTH; i++) begin
      gap = $urandom % 3;
      repeat (gap) begin
        wren = 1'b0;
        din  = sample_t'($urandom);    // junk while idle
        step_cycle();
        check_flag("out_buff_full", out_buff_full, 1'b0);
      end
      wren = 1'b1;
      din  = trace_sample(burst, i);
      step_cycle();
      check_flag("out_buff_full", out_buff_full, 1'b0);
    end
    wren = 1'b0;
    din  = '0;
  endtask

  // bounded by the watchdog
  task automatic wait_full();
    while (out_buff_full !== 1'b1) begin
      step_cycle();
    end
  endtask

  task automatic read_in_order(input int burst);
    for (int j = 0; j < OUT_DEPTH; j++) begin
      read_ptr = out_addr_t'(j);
      step_cycle();                   // dout valid one edge later
      check_sample($sformatf("dout (read_ptr 0x%h)", read_ptr), dout, exp_payload(burst, j));
    end
  endtask

  task automatic read_shuffled(input int burst);
    int order [OUT_DEPTH];
    int pick;
    int tmp;
    for (int j = 0; j < OUT_DEPTH; j++) begin
      order[j] = j;
    end
    for (int j = OUT_DEPTH - 1; j > 0; j--) begin
      pick        = $urandom % (j + 1);
      tmp         = order[j];
      order[j]    = order[pick];
      order[pick] = tmp;
    end
    for (int j = 0; j < OUT_DEPTH; j++) begin
      read_ptr = out_addr_t'(order[j]);
      step_cycle();
      check_sample($sformatf("dout (read_ptr 0x%h)", read_ptr), dout,
                   exp_payload(burst, order[j]));
    end
  endtask

  // writes after the window is full must be dropped, also while the copy reads it
  task automatic pulse_extra_wren();
    for (int k = 0; k < EXTRA_PULSES; k++) begin
      wren = 1'b1;
      din  = sample_t'($urandom);
      step_cycle();
      wren = 1'b0;
      step_cycle();
    end
  endtask

  task automatic clear_burst();
    tx_done = 1'b1;
    step_cycle();
    tx_done = 1'b0;
    check_flag("out_buff_full", out_buff_full, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    clk       = 1'b0;
    rst_n     = 1'b0;
    tx_done   = 1'b0;
    wren      = 1'b0;
    din       = '0;
    read_ptr  = '0;
    $readmemh("tb/time_sync_trace.txt", trace_mem);
    if ($isunknown(trace_mem[TRACE_WORDS-1])) begin
      $display("trace file tb/time_sync_trace.txt is missing or too short");
      abort_run();
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_flag("out_buff_full", out_buff_full, 1'b0);

    for (int b = 0; b < BURSTS; b++) begin
      if (b > 0) begin
        clear_burst();    // next burst has its own offset
      end
      feed_burst(b);
      pulse_extra_wren();    // lands while the payload is being copied
      wait_full();
      check_idx("frame_idx", frame_idx, exp_frame_idx(b));
      read_in_order(b);
      read_shuffled(b);
    end

    $display("NO ERRORS");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: out_buff_full never rose within %0d cycles", WATCHDOG_CYCLES);
    abort_run();
  end

endmodule

// ==== tb/time_sync_trace.txt ====
// per burst: 128 input samples (16 per line), expected frame_idx, 48 expected payload
// all words are 8-bit two's complement hex
// burst 0: quiet line, training at 26, data symbols with prefixes
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 E0 E0 20 E0 20 E0
20 20 E0 E0 20 E0 20 E0 20 20 E0 E0 20 E0 21 DE
23 DC 30 CD CA 39 C4 3F 42 BB 48 B5 B2 51 54 A9
5A A3 0C F4 55 AB 01 FE 07 F9 11 EF 2A D6 63 9D
7F 80 0C F4 55 AB B0 A0 90 81 10 20 30 40 50 60
70 7F F0 E0 D0 C0 B0 A0 90 81 05 FB 0A F6 0F F1
14 EC 19 E7 1E E2 23 DD 28 D8 2D D3 32 CE 37 C9
// burst 0 frame_idx
1A
// burst 0 payload
30 CD CA 39 C4 3F 42 BB 48 B5 B2 51 54 A9 5A A3
01 FE 07 F9 11 EF 2A D6 63 9D 7F 80 0C F4 55 AB
10 20 30 40 50 60 70 7F F0 E0 D0 C0 B0 A0 90 81
// burst 1: quiet line, training at 41, every data symbol with its own prefix
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 C0 C0 C0 40 40 40 C0
40 C0 C0 C0 40 40 40 C0 40 C0 C0 C0 40 45 B7 6E
92 66 9A 71 8F 0B F5 3C C4 27 D9 48 B8 45 B7 6E
92 CD EF 13 57 3A 5B 7C 9D BE DF 01 23 45 67 89
AB CD EF 13 57 3D 2E 1F 0E F1 E2 D3 C4 B5 A6 97
88 79 6A 5B 4C 3D 2E 1F 0E AA 55 CC 33 99 66 77
// burst 1 frame_idx
29
// burst 1 payload
66 9A 71 8F 0B F5 3C C4 27 D9 48 B8 45 B7 6E 92
3A 5B 7C 9D BE DF 01 23 45 67 89 AB CD EF 13 57
F1 E2 D3 C4 B5 A6 97 88 79 6A 5B 4C 3D 2E 1F 0E

// ==== time_sync.f ====
design/tsync_pkg.sv
design/sample_ram.sv
design/metric_calc.sv
design/peak_search.sv
design/cp_remover.sv
design/time_sync.sv
tb/tb_time_sync.sv
